/* src/mm_pkg.sv */
// ##############################
// matmul accelerator package
// sizes, payload types and the
// DMA controller state encoding
// ##############################

package mm_pkg;

    // grid side and matrix size
    localparam int SA_WIDTH = 4;

    // one signed element
    localparam int ELEM_W = 8;

    // a memory word packs one full column of A or row of B
    localparam int WORD_W = SA_WIDTH * ELEM_W;

    // AXI byte address
    localparam int ADDR_W = 32;

    // index into a buffer of SA_WIDTH words
    localparam int BUF_AW = $clog2(SA_WIDTH);

    // product width plus headroom for SA_WIDTH sums
    localparam int ACC_W = 2 * ELEM_W + $clog2(SA_WIDTH);

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic        [WORD_W-1:0] word_t;
    typedef logic        [ADDR_W-1:0] addr_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // DMA sequence: load A, load B, run engine, store C
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOAD_A  = 3'd1,
        LOAD_B  = 3'd2,
        WAIT_MM = 3'd3,
        STORE_C = 3'd4
    } dma_state_t;

endpackage

/* src/mm_buffer.sv */
// ##############################
// operand buffer
// one write port, registered read
// ##############################

`timescale 1ns/1ps

module mm_buffer (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  logic [mm_pkg::BUF_AW-1:0]   wr_addr_i,
    input  mm_pkg::word_t               wr_data_i,
    input  logic [mm_pkg::BUF_AW-1:0]   rd_addr_i,
    output mm_pkg::word_t               rd_data_o
);

    // one word per column of A or row of B
    mm_pkg::word_t mem [mm_pkg::SA_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // data shows up the cycle after the address
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* src/mm_pe.sv */
// ##############################
// multiply-accumulate cell
// signed MAC with clear and enable
// ##############################

`timescale 1ns/1ps

module mm_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear_i,
    input  logic            en_i,
    input  mm_pkg::elem_t   a_i,
    input  mm_pkg::elem_t   b_i,
    output mm_pkg::acc_t    acc_o
);

    // full-width signed product
    logic signed [2*mm_pkg::ELEM_W-1:0] prod;

    mm_pkg::acc_t acc_q;

    assign prod = a_i * b_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (clear_i) begin
            // new run starts from zero
            acc_q <= '0;
        end else if (en_i) begin
            // sign-extend product into the accumulator
            acc_q <= acc_q + mm_pkg::acc_t'(prod);
        end
    end

    // holds its value until the next clear
    assign acc_o = acc_q;

endmodule

/* src/mm_engine.sv */
// ##############################
// matrix engine
// steps k over both buffers and
// drives a grid of MAC cells
// ##############################

`timescale 1ns/1ps

module mm_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mm_start_i,
    output logic [mm_pkg::BUF_AW-1:0]   buf_a_raddr_o,
    input  mm_pkg::word_t               buf_a_rdata_i,
    output logic [mm_pkg::BUF_AW-1:0]   buf_b_raddr_o,
    input  mm_pkg::word_t               buf_b_rdata_i,
    output logic                        mm_done_o,
    output mm_pkg::acc_t                accum_o [mm_pkg::SA_WIDTH][mm_pkg::SA_WIDTH]
);

    // read phase active, one address per cycle
    logic                       run_q;
    // step counter k
    logic [mm_pkg::BUF_AW-1:0]  k_q;
    logic                       k_last;

    // MAC enable, one cycle behind the read address
    logic                       mac_en_q;
    // marks the final MAC step
    logic                       mac_last_q;
    logic                       done_q;

    // unpacked operands of the current step
    mm_pkg::elem_t a_col [mm_pkg::SA_WIDTH];
    mm_pkg::elem_t b_row [mm_pkg::SA_WIDTH];

    assign k_last = (k_q == mm_pkg::BUF_AW'(mm_pkg::SA_WIDTH - 1));

    // start cycle only arms the counter
    // addresses 0..SA_WIDTH-1 go out on the following cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            k_q   <= '0;
        end else if (mm_start_i) begin
            run_q <= 1'b1;
            k_q   <= '0;
        end else if (run_q) begin
            k_q <= k_q + 1'b1;
            if (k_last) begin
                run_q <= 1'b0;
            end
        end
    end

    // both buffers read word k in lockstep
    assign buf_a_raddr_o = k_q;
    assign buf_b_raddr_o = k_q;

    // enable lines up with registered read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_en_q   <= 1'b0;
            mac_last_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            mac_en_q   <= run_q;
            mac_last_q <= run_q && k_last;
            // done one cycle after the last MAC
            done_q     <= mac_last_q;
        end
    end

    assign mm_done_o = done_q;

    // split words into elements
    // column word k of A gives A(i,k), row word k of B gives B(k,j)
    always_comb begin
        for (int i = 0; i < mm_pkg::SA_WIDTH; i++) begin
            a_col[i] = buf_a_rdata_i[i*mm_pkg::ELEM_W +: mm_pkg::ELEM_W];
            b_row[i] = buf_b_rdata_i[i*mm_pkg::ELEM_W +: mm_pkg::ELEM_W];
        end
    end

    // cell (i,j) accumulates A(i,k) * B(k,j) over k
    // A broadcast along row i, B along column j
    for (genvar gi = 0; gi < mm_pkg::SA_WIDTH; gi++) begin : g_row
        for (genvar gj = 0; gj < mm_pkg::SA_WIDTH; gj++) begin : g_col
            mm_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (mm_start_i),
                .en_i    (mac_en_q),
                .a_i     (a_col[gi]),
                .b_i     (b_row[gj]),
                .acc_o   (accum_o[gi][gj])
            );
        end
    end

endmodule

/* src/dma_engine.sv */
// ##############################
// DMA engine
// AXI4-Lite master: loads A and B,
// runs the engine, stores C
// ##############################

`timescale 1ns/1ps

module dma_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mm_pkg::addr_t               mat_a_addr_i,
    input  mm_pkg::addr_t               mat_b_addr_i,
    input  mm_pkg::addr_t               mat_c_addr_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        busy_o,
    output mm_pkg::addr_t               araddr_o,
    output logic                        arvalid_o,
    input  logic                        arready_i,
    input  mm_pkg::word_t               rdata_i,
    input  logic [1:0]                  rresp_i,
    input  logic                        rvalid_i,
    output logic                        rready_o,
    output mm_pkg::addr_t               awaddr_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output mm_pkg::word_t               wdata_o,
    output logic [mm_pkg::WORD_W/8-1:0] wstrb_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    input  logic [1:0]                  bresp_i,
    input  logic                        bvalid_i,
    output logic                        bready_o,
    output logic                        buf_a_wren_o,
    output logic                        buf_b_wren_o,
    output logic [mm_pkg::BUF_AW-1:0]   buf_waddr_o,
    output mm_pkg::word_t               buf_wdata_o,
    output logic                        mm_start_o,
    input  logic                        mm_done_i,
    input  mm_pkg::acc_t                accum_i [mm_pkg::SA_WIDTH][mm_pkg::SA_WIDTH]
);

    localparam int IDX_W = 2 * mm_pkg::BUF_AW;

    mm_pkg::dma_state_t state_q;

    // word counter, upper half is the C row, lower half the column
    logic [IDX_W-1:0]   idx_q;
    logic               load_last;
    logic               store_last;

    logic               arvalid_q, rready_q;
    logic               awvalid_q, wvalid_q, bready_q;
    logic               r_hs, b_hs;
    logic               aw_ok, w_ok;
    logic               mm_start_q, done_q;

    // bases latched at start
    mm_pkg::addr_t      a_base_q, b_base_q, c_base_q;
    mm_pkg::addr_t      rd_base;
    mm_pkg::acc_t       c_elem;

    assign load_last  = (idx_q == IDX_W'(mm_pkg::SA_WIDTH - 1));
    assign store_last = (idx_q == IDX_W'(mm_pkg::SA_WIDTH * mm_pkg::SA_WIDTH - 1));

    assign r_hs = rready_q && rvalid_i;
    assign b_hs = bready_q && bvalid_i;
    // each write channel is done once its handshake has happened
    assign aw_ok = !awvalid_q || awready_i;
    assign w_ok  = !wvalid_q || wready_i;

    always_ff @(posedge clk) begin
        if (state_q == mm_pkg::IDLE && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= mm_pkg::IDLE;
            idx_q      <= '0;
            arvalid_q  <= 1'b0;
            rready_q   <= 1'b0;
            awvalid_q  <= 1'b0;
            wvalid_q   <= 1'b0;
            bready_q   <= 1'b0;
            mm_start_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            mm_start_q <= 1'b0;
            done_q     <= 1'b0;
            case (state_q)
                mm_pkg::IDLE: begin
                    if (start_i) begin
                        state_q   <= mm_pkg::LOAD_A;
                        idx_q     <= '0;
                        arvalid_q <= 1'b1;
                    end
                end
                mm_pkg::LOAD_A, mm_pkg::LOAD_B: begin
                    // address accepted, now wait for data
                    if (arvalid_q && arready_i) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                    end
                    if (r_hs) begin
                        rready_q <= 1'b0;
                        if (!load_last) begin
                            idx_q     <= idx_q + 1'b1;
                            arvalid_q <= 1'b1;
                        end else if (state_q == mm_pkg::LOAD_A) begin
                            state_q   <= mm_pkg::LOAD_B;
                            idx_q     <= '0;
                            arvalid_q <= 1'b1;
                        end else begin
                            // both operands in place
                            state_q    <= mm_pkg::WAIT_MM;
                            mm_start_q <= 1'b1;
                        end
                    end
                end
                mm_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q   <= mm_pkg::STORE_C;
                        idx_q     <= '0;
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                    end
                end
                mm_pkg::STORE_C: begin
                    if (awready_i) begin
                        awvalid_q <= 1'b0;
                    end
                    if (wready_i) begin
                        wvalid_q <= 1'b0;
                    end
                    // both AW and W through, wait for the response
                    if ((awvalid_q || wvalid_q) && aw_ok && w_ok) begin
                        bready_q <= 1'b1;
                    end
                    if (b_hs) begin
                        bready_q <= 1'b0;
                        if (store_last) begin
                            state_q <= mm_pkg::IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            idx_q     <= idx_q + 1'b1;
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= mm_pkg::IDLE;
            endcase
        end
    end

    // payloads come from stable registers, so they hold while valid is up
    // word index times 4 bytes
    assign rd_base  = (state_q == mm_pkg::LOAD_B) ? b_base_q : a_base_q;
    assign araddr_o = rd_base + mm_pkg::addr_t'({idx_q, 2'b00});
    assign awaddr_o = c_base_q + mm_pkg::addr_t'({idx_q, 2'b00});

    // C in row-major order, one sign-extended element per word
    assign c_elem  = accum_i[idx_q[IDX_W-1:mm_pkg::BUF_AW]][idx_q[mm_pkg::BUF_AW-1:0]];
    assign wdata_o = {{(mm_pkg::WORD_W - mm_pkg::ACC_W){c_elem[mm_pkg::ACC_W-1]}}, c_elem};
    assign wstrb_o = '1;

    assign arvalid_o = arvalid_q;
    assign rready_o  = rready_q;
    assign awvalid_o = awvalid_q;
    assign wvalid_o  = wvalid_q;
    assign bready_o  = bready_q;

    // buffer write on the R handshake cycle
    // rresp_i and bresp_i are taken as OKAY
    assign buf_a_wren_o = r_hs && (state_q == mm_pkg::LOAD_A);
    assign buf_b_wren_o = r_hs && (state_q == mm_pkg::LOAD_B);
    assign buf_waddr_o  = idx_q[mm_pkg::BUF_AW-1:0];
    assign buf_wdata_o  = rdata_i;

    assign mm_start_o = mm_start_q;
    assign done_o     = done_q;
    assign busy_o     = (state_q != mm_pkg::IDLE);

endmodule

/* src/matmul_accel_top.sv */
// ##############################
// matmul accelerator top
// DMA engine, two operand buffers
// and the matrix engine
// ##############################

`timescale 1ns/1ps

module matmul_accel_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mm_pkg::addr_t               mat_a_addr_i,
    input  mm_pkg::addr_t               mat_b_addr_i,
    input  mm_pkg::addr_t               mat_c_addr_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        busy_o,
    output mm_pkg::addr_t               araddr_o,
    output logic                        arvalid_o,
    input  logic                        arready_i,
    input  mm_pkg::word_t               rdata_i,
    input  logic [1:0]                  rresp_i,
    input  logic                        rvalid_i,
    output logic                        rready_o,
    output mm_pkg::addr_t               awaddr_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output mm_pkg::word_t               wdata_o,
    output logic [mm_pkg::WORD_W/8-1:0] wstrb_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    input  logic [1:0]                  bresp_i,
    input  logic                        bvalid_i,
    output logic                        bready_o
);

    // DMA to buffer write side
    logic                       buf_a_wren, buf_b_wren;
    logic [mm_pkg::BUF_AW-1:0]  buf_waddr;
    mm_pkg::word_t              buf_wdata;

    // engine to buffer read side
    logic [mm_pkg::BUF_AW-1:0]  buf_a_raddr, buf_b_raddr;
    mm_pkg::word_t              buf_a_rdata, buf_b_rdata;

    // engine handshake and results
    logic                       mm_start, mm_done;
    mm_pkg::acc_t               accum [mm_pkg::SA_WIDTH][mm_pkg::SA_WIDTH];

    dma_engine u_dma (
        .clk          (clk),          .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i), .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),      .done_o       (done_o),
        .busy_o       (busy_o),
        .araddr_o     (araddr_o),     .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rdata_i      (rdata_i),      .rresp_i      (rresp_i),
        .rvalid_i     (rvalid_i),     .rready_o     (rready_o),
        .awaddr_o     (awaddr_o),     .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wdata_o      (wdata_o),      .wstrb_o      (wstrb_o),
        .wvalid_o     (wvalid_o),     .wready_i     (wready_i),
        .bresp_i      (bresp_i),      .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .buf_a_wren_o (buf_a_wren),   .buf_b_wren_o (buf_b_wren),
        .buf_waddr_o  (buf_waddr),    .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),     .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    // columns of A
    mm_buffer u_buf_a (
        .clk (clk), .wr_en_i (buf_a_wren), .wr_addr_i (buf_waddr),
        .wr_data_i (buf_wdata), .rd_addr_i (buf_a_raddr), .rd_data_o (buf_a_rdata)
    );

    // rows of B
    mm_buffer u_buf_b (
        .clk (clk), .wr_en_i (buf_b_wren), .wr_addr_i (buf_waddr),
        .wr_data_i (buf_wdata), .rd_addr_i (buf_b_raddr), .rd_data_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk           (clk),         .rst_n         (rst_n),
        .mm_start_i    (mm_start),
        .buf_a_raddr_o (buf_a_raddr), .buf_a_rdata_i (buf_a_rdata),
        .buf_b_raddr_o (buf_b_raddr), .buf_b_rdata_i (buf_b_rdata),
        .mm_done_o     (mm_done),     .accum_o       (accum)
    );

endmodule

/* verif/axi_mem_model.sv */
// ##############################
// AXI4-Lite slave memory
// random ready stalls, random
// response delays, valid checks
// ##############################

`timescale 1ns/1ps

module axi_mem_model (
    input  logic                        clk,
    input  mm_pkg::addr_t               araddr_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output mm_pkg::word_t               rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    input  mm_pkg::addr_t               awaddr_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  mm_pkg::word_t               wdata_i,
    input  logic [mm_pkg::WORD_W/8-1:0] wstrb_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    output logic                        proto_err_o
);

    localparam int MEM_WORDS = 1024;

    mm_pkg::word_t mem [MEM_WORDS];

    integer        seed;
    // handshakes that happen at the coming edge
    logic          ar_hs, aw_hs, w_hs, r_hs, b_hs;
    // valid up without ready, payload must hold
    logic          ar_wait, aw_wait, w_wait;
    logic          bad;
    mm_pkg::addr_t ar_last, aw_last, rd_addr, wr_addr;
    mm_pkg::word_t w_last, wr_data;
    logic          have_aw, have_w, r_pend, b_pend;
    int            r_delay, b_delay;

    initial begin
        seed = 32'h13d4f282;
        {arready_o, rvalid_o, awready_o, wready_o, bvalid_o, proto_err_o} = '0;
        rdata_o = '0;
        rresp_o = 2'b00;
        bresp_o = 2'b00;
        {ar_wait, aw_wait, w_wait, have_aw, have_w, r_pend, b_pend} = '0;
        r_delay = 0;
        b_delay = 0;
        forever begin
            // master side is settled mid-cycle and holds to the edge
            @(negedge clk);
            bad = (ar_wait && (!arvalid_i || araddr_i != ar_last)) ||
                  (aw_wait && (!awvalid_i || awaddr_i != aw_last)) ||
                  (w_wait && (!wvalid_i || wdata_i != w_last));
            if (bad) begin
                $display("axi_mem_model: valid dropped or payload changed before handshake at %0t",
                         $time);
            end
            ar_hs   = arvalid_i && arready_o;
            aw_hs   = awvalid_i && awready_o;
            w_hs    = wvalid_i && wready_o;
            r_hs    = rvalid_o && rready_i;
            b_hs    = bvalid_o && bready_i;
            // only a known high valid has to be held
            ar_wait = (arvalid_i === 1'b1) && !arready_o;
            aw_wait = (awvalid_i === 1'b1) && !awready_o;
            w_wait  = (wvalid_i === 1'b1) && !wready_o;
            ar_last = araddr_i;
            aw_last = awaddr_i;
            w_last  = wdata_i;
            if (ar_hs) begin
                rd_addr = araddr_i;
            end
            if (aw_hs) begin
                wr_addr = awaddr_i;
            end
            if (w_hs) begin
                wr_data = wdata_i;
            end
            @(posedge clk);
            #2;
            if (r_hs) begin
                rvalid_o = 1'b0;
            end
            if (b_hs) begin
                bvalid_o = 1'b0;
            end
            if (ar_hs) begin
                r_pend  = 1'b1;
                r_delay = $random(seed) & 3;
            end
            have_aw = have_aw || aw_hs;
            have_w  = have_w || w_hs;
            // write lands once address and data are both in
            if (have_aw && have_w) begin
                mem[wr_addr[11:2]] = wr_data;
                have_aw = 1'b0;
                have_w  = 1'b0;
                b_pend  = 1'b1;
                b_delay = $random(seed) & 3;
            end
            if (r_pend) begin
                if (r_delay == 0) begin
                    rvalid_o = 1'b1;
                    rdata_o  = mem[rd_addr[11:2]];
                    r_pend   = 1'b0;
                end else begin
                    r_delay--;
                end
            end
            if (b_pend) begin
                if (b_delay == 0) begin
                    bvalid_o = 1'b1;
                    b_pend   = 1'b0;
                end else begin
                    b_delay--;
                end
            end
            // ready about three cycles in four
            arready_o   = ($random(seed) & 3) != 0;
            awready_o   = ($random(seed) & 3) != 0;
            wready_o    = ($random(seed) & 3) != 0;
            proto_err_o = proto_err_o || bad;
        end
    end

endmodule

/* verif/tb_matmul_accel.sv */
// ##############################
// matmul accelerator testbench
// runs file cases through the
// AXI memory model, checks C
// ##############################

`timescale 1ns/1ps

module tb_matmul_accel;

    localparam int N_CASES     = 3;
    localparam int C_WORDS     = mm_pkg::SA_WIDTH * mm_pkg::SA_WIDTH;
    // A words, B words, three bases, C elements
    localparam int OFS_BASE    = 2 * mm_pkg::SA_WIDTH;
    localparam int OFS_C       = OFS_BASE + 3;
    localparam int CASE_WORDS  = OFS_C + C_WORDS;
    localparam int MEM_WORDS   = 1024;
    localparam int CYCLE_LIMIT = N_CASES * 200;

    logic                        clk;
    logic                        rst_n;
    mm_pkg::addr_t               mat_a_addr, mat_b_addr, mat_c_addr;
    logic                        start, done, busy;
    mm_pkg::addr_t               araddr, awaddr;
    logic                        arvalid, arready, rvalid, rready;
    logic                        awvalid, awready, wvalid, wready, bvalid, bready;
    mm_pkg::word_t               rdata, wdata;
    logic [1:0]                  rresp, bresp;
    logic [mm_pkg::WORD_W/8-1:0] wstrb;
    logic                        proto_err;

    mm_pkg::word_t cases [N_CASES * CASE_WORDS];
    // memory image before the run
    mm_pkg::word_t snap  [MEM_WORDS];
    int            cycles;

    matmul_accel_top dut (
        .clk          (clk),        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr), .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start),      .done_o       (done),       .busy_o    (busy),
        .araddr_o     (araddr),     .arvalid_o    (arvalid),    .arready_i (arready),
        .rdata_i      (rdata),      .rresp_i      (rresp),
        .rvalid_i     (rvalid),     .rready_o     (rready),
        .awaddr_o     (awaddr),     .awvalid_o    (awvalid),    .awready_i (awready),
        .wdata_o      (wdata),      .wstrb_o      (wstrb),
        .wvalid_o     (wvalid),     .wready_i     (wready),
        .bresp_i      (bresp),      .bvalid_i     (bvalid),     .bready_o  (bready)
    );

    axi_mem_model mem_model (
        .clk       (clk),
        .araddr_i  (araddr),  .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o   (rdata),   .rresp_o   (rresp),
        .rvalid_o  (rvalid),  .rready_i  (rready),
        .awaddr_i  (awaddr),  .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i   (wdata),   .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),  .wready_o  (wready),
        .bresp_o   (bresp),   .bvalid_o  (bvalid),  .bready_i  (bready),
        .proto_err_o (proto_err)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input mm_pkg::word_t got, input mm_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s, expected %h, got %h",
                                        $time, what, exp, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s, expected %b, got %b",
                                        $time, what, exp, got));
        end
    endtask

    // operands into memory, then a snapshot of the whole array
    task automatic load_case(input int c);
        int base;
        int a_w;
        int b_w;
        base = c * CASE_WORDS;
        a_w  = int'(cases[base + OFS_BASE] >> 2);
        b_w  = int'(cases[base + OFS_BASE + 1] >> 2);
        for (int k = 0; k < mm_pkg::SA_WIDTH; k++) begin
            mem_model.mem[a_w + k] = cases[base + k];
            mem_model.mem[b_w + k] = cases[base + mm_pkg::SA_WIDTH + k];
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            snap[w] = mem_model.mem[w];
        end
    endtask

    // busy until done, and every C store answered before done
    task automatic wait_done();
        int b_cnt;
        b_cnt = 0;
        @(negedge clk);
        while (!done) begin
            check_flag(busy, 1'b1, "busy_o high while the run is in progress");
            if (wvalid) begin
                check_flag(&wstrb, 1'b1, "wstrb all ones");
            end
            if (bvalid && bready) begin
                b_cnt++;
            end
            @(negedge clk);
        end
        check_flag(busy, 1'b0, "busy_o low with done_o");
        check_word(mm_pkg::word_t'(b_cnt), mm_pkg::word_t'(C_WORDS),
                   "write responses before done_o");
    endtask

    // C area holds the expected words, everything else is unchanged
    task automatic check_memory(input int c);
        int base;
        int c_w;
        base = c * CASE_WORDS;
        c_w  = int'(cases[base + OFS_BASE + 2] >> 2);
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (w >= c_w && w < c_w + C_WORDS) begin
                check_word(mem_model.mem[w], cases[base + OFS_C + w - c_w],
                           $sformatf("case %0d C word %0d", c, w - c_w));
            end else begin
                check_word(mem_model.mem[w], snap[w],
                           $sformatf("case %0d word %0d outside C", c, w));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length limit
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                stop_with_failure($sformatf("timeout: no end of run after %0d cycles", cycles));
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            check_flag(proto_err, 1'b0, "AXI valid and payload held until handshake");
        end
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            // background differs at every word address
            mem_model.mem[w] = (mm_pkg::word_t'(w) * 32'h9e3779b1) ^ 32'h0f0f5a5a;
        end
        $readmemh("verif/matmul_cases.txt", cases);
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(done, 1'b0, "done_o low after reset");
        check_flag(busy, 1'b0, "busy_o low after reset");
        check_flag(arvalid, 1'b0, "arvalid low after reset");
        check_flag(awvalid, 1'b0, "awvalid low after reset");
        check_flag(wvalid, 1'b0, "wvalid low after reset");
        check_flag(rready, 1'b0, "rready low after reset");
        check_flag(bready, 1'b0, "bready low after reset");
        for (int c = 0; c < N_CASES; c++) begin
            load_case(c);
            // from the second case on this start is the cycle after done_o
            @(posedge clk);
            #2;
            mat_a_addr = cases[c * CASE_WORDS + OFS_BASE];
            mat_b_addr = cases[c * CASE_WORDS + OFS_BASE + 1];
            mat_c_addr = cases[c * CASE_WORDS + OFS_BASE + 2];
            start      = 1'b1;
            // the previous done_o pulse is already over
            @(negedge clk);
            check_flag(done, 1'b0, "done_o is a one-cycle pulse");
            @(posedge clk);
            #2;
            start = 1'b0;
            @(negedge clk);
            check_flag(busy, 1'b1, "busy_o high the cycle after start");
            // extra start while busy
            @(posedge clk);
            #2;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
            wait_done();
            check_memory(c);
        end
        // ignored starts must not leave a second run behind
        repeat (20) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "no extra run after the last case");
            check_flag(done, 1'b0, "done_o once per run");
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* verif/matmul_cases.txt */
// per case: A column words 0-3 then B row words 0-3 / A, B, C byte bases
// then the 16 C elements row-major, each sign-extended to 32 bits
// identity times B
00000001 00000100 00010000 01000000 04030201 FCFDFEFF 0500807F 28E2140A
00000000 00000040 00000080
00000001 00000002 00000003 00000004 FFFFFFFF FFFFFFFE FFFFFFFD FFFFFFFC
0000007F FFFFFF80 00000000 00000005 0000000A 00000014 FFFFFFE2 00000028
// all 127 times all -128
7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 80808080 80808080 80808080 80808080
00000100 00000140 00000180
FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200
FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200 FFFF0200
// mixed small values
FF000301 0001FE02 01020100 020100FF FF010002 02000101 0103FF00 00000201
00000200 00000220 00000300
00000003 00000000 00000001 00000003 00000004 FFFFFFFD 00000006 FFFFFFFA
00000002 00000001 00000006 00000004 00000000 00000003 00000002 00000002

/* sim.f */
src/mm_pkg.sv
src/mm_buffer.sv
src/mm_pe.sv
src/mm_engine.sv
src/dma_engine.sv
src/matmul_accel_top.sv
verif/axi_mem_model.sv
verif/tb_matmul_accel.sv

/* Makefile */
TOP = tb_matmul_accel

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
